/* design/controlOutputs.sv */
`timescale 1ns/1ps

module controlOutputs (
	input controlPkg::ctlState_t state,
	decodeIf.outputs dec,
	output logic clearPC,
	output logic regFileRW,
	output logic pcEnable,
	output logic irEnable,
	output logic marEnable,
	output logic mdrEnable,
	output logic ramMFA,
	output logic trapMux,
	output logic signExtend,
	output logic muxSignals2, // MDR input select
	output controlPkg::regAddr_t regFileRD,
	output controlPkg::regAddr_t regFileRS,
	output controlPkg::regAddr_t regFileRT,
	output controlPkg::aluOp_t aluOperation,
	output controlPkg::aluSign_t aluSign,
	output controlPkg::aluSrc_t muxSignals, // ALU B mux
	output controlPkg::ramAddr_t ramAddress
);
	import controlPkg::*;

	always_comb begin
		clearPC = 1'b0;
		regFileRW = 1'b0;
		pcEnable = 1'b0;
		irEnable = 1'b0;
		marEnable = 1'b0;
		mdrEnable = 1'b0;
		ramMFA = 1'b0;
		trapMux = 1'b0;
		muxSignals2 = 1'b0;
		ramAddress = '0;

		// decoded fields by default
		signExtend = dec.signExtend;
		regFileRS = dec.rs;
		regFileRT = dec.rt;
		regFileRD = dec.dest;
		aluOperation = dec.aluOp;
		aluSign = dec.aluSign;
		muxSignals = dec.aluSrc;

		case (state)
			stReset: clearPC = 1'b1;
			stFetchAddr: begin
				marEnable = 1'b1;
				aluOperation = aluPass; // MAR gets PC through the ALU
				aluSign = signUnsAdd;
				muxSignals = srcPc;
			end
			stFetchReq: begin
				pcEnable = 1'b1;
				ramMFA = 1'b1;
				aluOperation = aluPcInc;
				aluSign = signUnsAdd;
				muxSignals = srcPc;
			end
			stFetchWait: begin
				ramMFA = 1'b1; // held until ramMFC
				aluOperation = aluPcInc;
				aluSign = signUnsAdd;
				muxSignals = srcPc;
			end
			stFetchLoad: begin
				irEnable = 1'b1;
				aluOperation = aluPcInc;
				aluSign = signUnsAdd;
				muxSignals = srcPc;
			end
			stExec: regFileRW = 1'b1;
			stCommit: regFileRW = 1'b1; // overflow clear
			stTrapVector: begin
				trapMux = 1'b1;
				ramMFA = 1'b1;
				ramAddress = trapVectorAddr;
			end
			stLwAddr: marEnable = 1'b1; // base + offset into MAR
			stLwWait: ramMFA = 1'b1;
			stLwCapture: begin
				mdrEnable = 1'b1;
				muxSignals2 = 1'b1;
			end
			stLwWrite: begin
				aluOperation = aluPass;
				muxSignals = srcMdr;
				muxSignals2 = 1'b1;
				regFileRW = 1'b1; // dest is rt for lw
			end
			default: begin
				// decode, execute and check states keep the defaults
			end
		endcase
	end

endmodule

/* design/controlPkg.sv */
package controlPkg;

	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int aluOpWidth = 4;
	localparam int ramAddrWidth = 9;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [aluOpWidth-1:0] aluOp_t;
	typedef logic [1:0] aluSign_t; // bit 1 signed, bit 0 subtract
	typedef logic [1:0] aluSrc_t; // B input of the ALU
	typedef logic [ramAddrWidth-1:0] ramAddr_t;

	// opcodes in instruction[31:26]
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opLw = 6'b100011;

	// function codes under opSpecial
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;

	// ALU operation codes
	localparam aluOp_t aluPass = 4'b0000;
	localparam aluOp_t aluAdd = 4'b0001; // add and sub picked by sign mode
	localparam aluOp_t aluAnd = 4'b0100;
	localparam aluOp_t aluOr = 4'b0101;
	localparam aluOp_t aluXor = 4'b1100;
	localparam aluOp_t aluSrl = 4'b0111;
	localparam aluOp_t aluSll = 4'b1000;
	localparam aluOp_t aluSra = 4'b1001;
	localparam aluOp_t aluLui = 4'b1010;
	localparam aluOp_t aluPcInc = 4'b1011;

	localparam aluSign_t signUnsAdd = 2'b00;
	localparam aluSign_t signUnsSub = 2'b01;
	localparam aluSign_t signAdd = 2'b10;
	localparam aluSign_t signSub = 2'b11;

	localparam aluSrc_t srcReg = 2'b00;
	localparam aluSrc_t srcImm = 2'b01;
	localparam aluSrc_t srcMdr = 2'b10;
	localparam aluSrc_t srcPc = 2'b11;

	localparam ramAddr_t trapVectorAddr = 9'd448; // overflow handler

	typedef enum logic [1:0] {
		kindAlu,
		kindAluTrap, // signed ops with overflow check
		kindLoadWord,
		kindInvalid
	} instrKind_t;

	typedef enum logic [3:0] {
		stReset,
		stFetchAddr,
		stFetchReq,
		stFetchWait,
		stFetchLoad,
		stDecode,
		stExec,
		stExecTrap,
		stOverflowCheck,
		stCommit,
		stTrapVector,
		stLwAddr,
		stLwWait,
		stLwCapture,
		stLwWrite
	} ctlState_t;

endpackage

/* design/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
	input logic Clk,
	input logic rstN,
	input logic ramMFC,
	input logic aluOverflow,
	decodeIf.sequencer dec,
	output controlPkg::ctlState_t state
);
	import controlPkg::*;

	ctlState_t nextState;

	always_ff @(posedge Clk) begin
		if (!rstN)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			stReset: nextState = stFetchAddr;
			stFetchAddr: nextState = stFetchReq;
			stFetchReq: nextState = stFetchWait;
			stFetchWait: begin
				if (ramMFC)
					nextState = stFetchLoad;
			end
			stFetchLoad: nextState = stDecode;
			stDecode: begin
				case (dec.kind)
					kindAlu: nextState = stExec;
					kindAluTrap: nextState = stExecTrap;
					kindLoadWord: nextState = stLwAddr;
					default: nextState = stFetchAddr; // invalid word skips any write
				endcase
			end
			stExec: nextState = stFetchAddr;
			stExecTrap: nextState = stOverflowCheck;
			stOverflowCheck: begin
				// flag settles while ALU settings are held
				if (aluOverflow)
					nextState = stTrapVector;
				else
					nextState = stCommit;
			end
			stCommit: nextState = stFetchAddr;
			stTrapVector: nextState = stFetchWait; // fetch handler word
			stLwAddr: nextState = stLwWait;
			stLwWait: begin
				if (ramMFC)
					nextState = stLwCapture;
			end
			stLwCapture: nextState = stLwWrite;
			stLwWrite: nextState = stFetchAddr;
			default: nextState = stFetchAddr;
		endcase
	end

	// memory waits need a defined completion strobe
	assert property (@(posedge Clk) disable iff (!rstN)
		(state == stFetchWait || state == stLwWait) |-> !$isunknown(ramMFC))
		else $error("controlSequencer: ramMFC unknown while waiting on memory");

	assert property (@(posedge Clk) disable iff (!rstN)
		state == stOverflowCheck |-> !$isunknown(aluOverflow))
		else $error("controlSequencer: aluOverflow unknown at the overflow check");

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input logic Clk,
	input logic rstN,
	input controlPkg::word_t instruction,
	input logic ramMFC,
	input logic aluOverflow,
	output logic clearPC,
	output logic regFileRW,
	output logic pcEnable,
	output logic irEnable,
	output logic marEnable,
	output logic mdrEnable,
	output logic ramMFA,
	output logic trapMux,
	output logic signExtend,
	output logic muxSignals2,
	output controlPkg::regAddr_t regFileRD,
	output controlPkg::regAddr_t regFileRS,
	output controlPkg::regAddr_t regFileRT,
	output controlPkg::aluOp_t aluOperation,
	output controlPkg::aluSign_t aluSign,
	output controlPkg::aluSrc_t muxSignals,
	output controlPkg::ramAddr_t ramAddress
);
	import controlPkg::*;

	ctlState_t state;

	decodeIf decBus ();

	// decoded word from IR
	instrDecoder instrDecoder_inst (
		.instruction(instruction),
		.dec(decBus.decoder)
	);

	controlSequencer controlSequencer_inst (
		.Clk(Clk),
		.rstN(rstN),
		.ramMFC(ramMFC),
		.aluOverflow(aluOverflow),
		.dec(decBus.sequencer),
		.state(state)
	);

	controlOutputs controlOutputs_inst (
		.state(state),
		.dec(decBus.outputs),
		.clearPC(clearPC),
		.regFileRW(regFileRW),
		.pcEnable(pcEnable),
		.irEnable(irEnable),
		.marEnable(marEnable),
		.mdrEnable(mdrEnable),
		.ramMFA(ramMFA),
		.trapMux(trapMux),
		.signExtend(signExtend),
		.muxSignals2(muxSignals2),
		.regFileRD(regFileRD),
		.regFileRS(regFileRS),
		.regFileRT(regFileRT),
		.aluOperation(aluOperation),
		.aluSign(aluSign),
		.muxSignals(muxSignals),
		.ramAddress(ramAddress)
	);

endmodule

/* design/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf;
	import controlPkg::*;

	instrKind_t kind;
	aluOp_t aluOp;
	aluSign_t aluSign;
	aluSrc_t aluSrc;
	logic signExtend; // imm16 sign extension
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t dest; // write-back register

	modport decoder (
		output kind, aluOp, aluSign, aluSrc, signExtend, rs, rt, dest
	);

	// sequencer only branches on the kind
	modport sequencer (
		input kind
	);

	modport outputs (
		input aluOp, aluSign, aluSrc, signExtend, rs, rt, dest
	);

endinterface

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
	input controlPkg::word_t instruction,
	decodeIf.decoder dec
);
	import controlPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rsField;
	regAddr_t rtField;
	regAddr_t rdField;

	assign opcode = instruction[31:26];
	assign funct = instruction[5:0];
	assign rsField = instruction[25:21];
	assign rtField = instruction[20:16];
	assign rdField = instruction[15:11];

	always_comb begin
		// register-register form unless overridden
		dec.kind = kindInvalid;
		dec.aluOp = aluPass;
		dec.aluSign = signUnsAdd;
		dec.aluSrc = srcReg;
		dec.signExtend = 1'b0;
		dec.rs = rsField;
		dec.rt = rtField;
		dec.dest = rdField;

		case (opcode)
			opSpecial: begin
				dec.kind = kindAlu;
				case (funct)
					fnAddu: dec.aluOp = aluAdd;
					fnAdd: begin
						dec.kind = kindAluTrap;
						dec.aluOp = aluAdd;
						dec.aluSign = signAdd;
					end
					fnSubu: begin
						dec.aluOp = aluAdd;
						dec.aluSign = signUnsSub;
					end
					fnSub: begin
						dec.kind = kindAluTrap;
						dec.aluOp = aluAdd;
						dec.aluSign = signSub;
					end
					fnAnd: dec.aluOp = aluAnd;
					fnOr: dec.aluOp = aluOr;
					fnXor: dec.aluOp = aluXor;
					fnSllv: dec.aluOp = aluSll; // shift amount from rs
					fnSrlv: dec.aluOp = aluSrl;
					fnSrav: dec.aluOp = aluSra;
					default: dec.kind = kindInvalid; // unknown function code
				endcase
			end
			opAddiu: begin
				dec.kind = kindAlu;
				dec.aluOp = aluAdd;
				dec.aluSrc = srcImm;
				dec.signExtend = 1'b1;
				dec.dest = rtField;
			end
			opAddi: begin
				dec.kind = kindAluTrap;
				dec.aluOp = aluAdd;
				dec.aluSign = signAdd;
				dec.aluSrc = srcImm;
				dec.signExtend = 1'b1;
				dec.dest = rtField;
			end
			opLui: begin
				dec.kind = kindAlu;
				dec.aluOp = aluLui;
				dec.aluSrc = srcImm; // zero-extended imm16
				dec.rs = rtField; // rt is source and target
				dec.dest = rtField;
			end
			opLw: begin
				dec.kind = kindLoadWord;
				dec.aluOp = aluAdd; // base + offset
				dec.aluSrc = srcImm;
				dec.signExtend = 1'b1;
				dec.dest = rtField;
			end
			default: dec.kind = kindInvalid;
		endcase
	end

endmodule

/* sim.f */
+incdir+testbench
design/controlPkg.sv
design/decodeIf.sv
design/instrDecoder.sv
design/controlSequencer.sv
design/controlOutputs.sv
design/controlUnit.sv
testbench/controlUnitTb.sv

/* testbench/controlUnitTests.svh */
localparam int numTests = 19;
localparam int outWrite = 0;
localparam int outTrap = 1;
localparam int outNone = 2;

string testName [numTests];
logic [31:0] testInstr [numTests];
logic testOvf [numTests];
int testOutcome [numTests];
int testDelay [numTests];
logic [3:0] testAluOp [numTests];
logic [1:0] testSign [numTests];
logic [1:0] testSrc [numTests];
logic testSext [numTests];
logic [4:0] testRd [numTests];
logic [4:0] testRs [numTests];
logic [4:0] testRt [numTests];
int rowCount = 0;

function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
	return {6'b000000, rs, rt, rd, 5'b00000, fn};
endfunction

function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic addRow(input string name, input logic [31:0] instr, input logic ovf,
		input int outcome, input int delay, input logic [3:0] aluOp, input logic [1:0] sign,
		input logic [1:0] src, input logic sext, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
	testName[rowCount] = name;
	testInstr[rowCount] = instr;
	testOvf[rowCount] = ovf;
	testOutcome[rowCount] = outcome;
	testDelay[rowCount] = delay;
	testAluOp[rowCount] = aluOp;
	testSign[rowCount] = sign;
	testSrc[rowCount] = src;
	testSext[rowCount] = sext;
	testRd[rowCount] = rd;
	testRs[rowCount] = rs;
	testRt[rowCount] = rt;
	rowCount++;
endtask

// row fields are name, instruction word, overflow flag, outcome, cycles from irEnable
// to write (0 when the latency varies), then aluOperation, aluSign, muxSignals,
// signExtend, regFileRD, regFileRS and regFileRT at the write
task automatic loadTests();
	addRow("addu", rType(1, 2, 3, 6'b100001), 0, outWrite, 2,
		4'b0001, 2'b00, 2'b00, 0, 3, 1, 2);
	addRow("add", rType(1, 2, 4, 6'b100000), 0, outWrite, 4,
		4'b0001, 2'b10, 2'b00, 0, 4, 1, 2);
	addRow("add ovf", rType(1, 2, 4, 6'b100000), 1, outTrap, 0,
		4'b0001, 2'b10, 2'b00, 0, 4, 1, 2);
	addRow("subu", rType(3, 4, 5, 6'b100011), 0, outWrite, 2,
		4'b0001, 2'b01, 2'b00, 0, 5, 3, 4);
	addRow("sub", rType(3, 4, 6, 6'b100010), 0, outWrite, 4,
		4'b0001, 2'b11, 2'b00, 0, 6, 3, 4);
	addRow("sub ovf", rType(3, 4, 6, 6'b100010), 1, outTrap, 0,
		4'b0001, 2'b11, 2'b00, 0, 6, 3, 4);
	addRow("and", rType(7, 8, 9, 6'b100100), 0, outWrite, 2,
		4'b0100, 2'b00, 2'b00, 0, 9, 7, 8);
	addRow("or", rType(7, 8, 10, 6'b100101), 0, outWrite, 2,
		4'b0101, 2'b00, 2'b00, 0, 10, 7, 8);
	addRow("xor", rType(7, 8, 11, 6'b100110), 0, outWrite, 2,
		4'b1100, 2'b00, 2'b00, 0, 11, 7, 8);
	addRow("sllv", rType(12, 13, 14, 6'b000100), 0, outWrite, 2,
		4'b1000, 2'b00, 2'b00, 0, 14, 12, 13);
	addRow("srlv", rType(12, 13, 15, 6'b000110), 0, outWrite, 2,
		4'b0111, 2'b00, 2'b00, 0, 15, 12, 13);
	addRow("srav", rType(12, 13, 16, 6'b000111), 0, outWrite, 2,
		4'b1001, 2'b00, 2'b00, 0, 16, 12, 13);
	addRow("addiu", iType(6'b001001, 5, 6, 16'hfff0), 0, outWrite, 2,
		4'b0001, 2'b00, 2'b01, 1, 6, 5, 6);
	addRow("lui", iType(6'b001111, 0, 7, 16'h1234), 0, outWrite, 2,
		4'b1010, 2'b00, 2'b01, 0, 7, 7, 7);
	addRow("addi", iType(6'b001000, 5, 17, 16'h0004), 0, outWrite, 4,
		4'b0001, 2'b10, 2'b01, 1, 17, 5, 17);
	addRow("addi ovf", iType(6'b001000, 5, 17, 16'h7fff), 1, outTrap, 0,
		4'b0001, 2'b10, 2'b01, 1, 17, 5, 17);
	addRow("lw", iType(6'b100011, 8, 9, 16'h0010), 0, outWrite, 0,
		4'b0000, 2'b00, 2'b10, 1, 9, 8, 9);
	addRow("bad opcode", iType(6'b111111, 1, 2, 16'h0000), 0, outNone, 0,
		4'b0000, 2'b00, 2'b00, 0, 0, 0, 0);
	addRow("bad funct", rType(1, 2, 3, 6'b111111), 0, outNone, 0,
		4'b0000, 2'b00, 2'b00, 0, 0, 0, 0);
endtask

/* testbench/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

	localparam int resetCycles = 4;
	localparam int cyclesPerRow = 20; // worst row is lw with two slow memory waits

	logic Clk = 1'b0;
	logic rstN;
	logic [31:0] instruction;
	logic ramMFC;
	logic aluOverflow;
	logic clearPC, regFileRW, pcEnable, irEnable, marEnable, mdrEnable;
	logic ramMFA, trapMux, signExtend, muxSignals2;
	logic [4:0] regFileRD, regFileRS, regFileRT;
	logic [3:0] aluOperation;
	logic [1:0] aluSign;
	logic [1:0] muxSignals;
	logic [8:0] ramAddress;

	int errorCount = 0;
	int mfcCount = 0; // completions raised by the responder
	logic [31:0] lfsr = 32'hc747_746c;

	`include "controlUnitTests.svh"

	controlUnit controlUnit_inst (.*);

	initial begin
		forever #5 Clk = ~Clk;
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003; // Galois taps 32,22,2,1
		return s >> 1;
	endfunction

	task automatic compareValue(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
			else begin
				errorCount++;
				$display("Fail %s %s: expected %0h, actual %0h", name, field, expected, actual);
			end
	endtask

	task automatic requireTrue(input logic cond, input string msg);
		assert (cond === 1'b1)
			else begin
				errorCount++;
				$display("%s", msg);
			end
	endtask

	// memory model answering ramMFA after 0 to 3 cycles
	initial begin
		int delay;
		ramMFC = 1'b0;
		forever begin
			@(negedge Clk);
			if (ramMFA === 1'b1 && !ramMFC) begin
				lfsr = lfsrStep(lfsr);
				delay = lfsr[0];
				lfsr = lfsrStep(lfsr);
				delay = delay * 2 + lfsr[0];
				repeat (delay) @(negedge Clk);
				ramMFC = 1'b1;
				mfcCount++;
			end else if (ramMFA === 1'b0) begin
				ramMFC = 1'b0;
			end
		end
	end

	initial begin
		int cyc;
		int lastMfc;
		bit done;
		bit sawLwAddr;
		bit sawMdr;
		rstN = 1'b0;
		instruction = '0;
		aluOverflow = 1'b0;
		lastMfc = 0;
		loadTests();
		repeat (resetCycles) begin
			@(negedge Clk);
			requireTrue(clearPC === 1'b1 && regFileRW === 1'b0 && pcEnable === 1'b0
				&& irEnable === 1'b0 && marEnable === 1'b0 && mdrEnable === 1'b0
				&& ramMFA === 1'b0 && trapMux === 1'b0 && muxSignals2 === 1'b0
				&& ramAddress === 9'd0,
				"clearPC low or a control line active during reset");
		end
		rstN = 1'b1;
		for (int i = 0; i < numTests; i++) begin
			@(negedge Clk);
			while (irEnable !== 1'b1) begin
				requireTrue(regFileRW !== 1'b1,
					$sformatf("register write between instructions before %s", testName[i]));
				@(negedge Clk);
			end
			requireTrue(mfcCount > lastMfc,
				$sformatf("%s: irEnable came without a memory completion", testName[i]));
			lastMfc = mfcCount;
			instruction = testInstr[i]; // held until the next irEnable
			aluOverflow = testOvf[i];
			cyc = 0;
			done = 1'b0;
			sawLwAddr = 1'b0;
			sawMdr = 1'b0;
			while (!done) begin
				@(negedge Clk);
				cyc++;
				if (regFileRW === 1'b1) begin
					done = 1'b1;
					compareValue(testName[i], "outcome", testOutcome[i], outWrite);
					if (testDelay[i] > 0)
						compareValue(testName[i], "write cycle", testDelay[i], cyc);
					else
						requireTrue(sawMdr, $sformatf("%s: write without mdrEnable", testName[i]));
					compareValue(testName[i], "aluOperation", testAluOp[i], aluOperation);
					compareValue(testName[i], "aluSign", testSign[i], aluSign);
					compareValue(testName[i], "muxSignals", testSrc[i], muxSignals);
					compareValue(testName[i], "signExtend", testSext[i], signExtend);
					compareValue(testName[i], "regFileRD", testRd[i], regFileRD);
					compareValue(testName[i], "regFileRS", testRs[i], regFileRS);
					compareValue(testName[i], "regFileRT", testRt[i], regFileRT);
					if (testDelay[i] == 0)
						compareValue(testName[i], "muxSignals2", 1, muxSignals2);
				end else if (trapMux === 1'b1) begin
					done = 1'b1;
					compareValue(testName[i], "outcome", testOutcome[i], outTrap);
					compareValue(testName[i], "ramAddress", 448, ramAddress);
					compareValue(testName[i], "ramMFA", 1, ramMFA);
				end else if (marEnable === 1'b1 && muxSignals === 2'b11 && clearPC === 1'b0) begin
					done = 1'b1; // back in fetch without a write
					compareValue(testName[i], "outcome", testOutcome[i], outNone);
				end else if (marEnable === 1'b1) begin
					sawLwAddr = 1'b1;
					compareValue(testName[i], "address muxSignals", 2'b01, muxSignals);
					compareValue(testName[i], "address signExtend", 1, signExtend);
				end else if (mdrEnable === 1'b1) begin
					requireTrue(sawLwAddr && mfcCount > lastMfc,
						$sformatf("%s: mdrEnable before the address or the completion", testName[i]));
					lastMfc = mfcCount;
					sawMdr = 1'b1;
				end
			end
		end
		$display("Checks done: %0d errors over %0d instructions", errorCount, numTests);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		repeat (resetCycles + numTests * cyclesPerRow) @(posedge Clk);
		$display("Timeout: instructions did not complete within %0d cycles",
			resetCycles + numTests * cyclesPerRow);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
